// File: delay_pkg.sv
`default_nettype none

package delay_pkg;

    // Lane 0 sample record
    typedef struct packed {
        logic [11:0] data;  // Upper bits
        logic [3:0]  tag;
    } sample_t;

    // Lane 1 payload
    typedef logic [7:0] flags_t;

    // Register write bus
    typedef struct packed {
        logic        wr;     // Single-cycle write strobe
        logic [1:0]  addr;
        logic [15:0] wdata;
    } cfg_wr_t;

    // Register map
    localparam logic [1:0] CFG_LEN0 = 2'd0;
    localparam logic [1:0] CFG_LEN1 = 2'd1;
    localparam logic [1:0] CFG_CTRL = 2'd2;  // Bit 0 selects LFSR source for lane 0
    localparam logic [1:0] CFG_SEED = 2'd3;

    // LFSR state width and reset seed
    localparam int LFSR_W = 16;
    localparam logic [LFSR_W-1:0] SEED_RESET = 16'h0001;

endpackage

`default_nettype wire

// File: delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module delay_line
    import delay_pkg::*;
#(
    parameter type payload_t = flags_t,
    parameter int  DEPTH     = 16,
    localparam int LEN_W     = $clog2(DEPTH)
) (
    input  wire logic             clk,
    input  wire logic             er,
    input  wire logic             shift_en,
    input  wire logic [LEN_W-1:0] len,
    input  wire payload_t         din,
    output payload_t              dout
);

    payload_t stage [DEPTH];  // stage[0] is the newest entry

    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            for (int k = 0; k < DEPTH; k++) begin
                stage[k] <= '0;
            end
        end else if (shift_en) begin
            stage[0] <= din;
            for (int k = 1; k < DEPTH; k++) begin
                stage[k] <= stage[k-1];
            end
        end
    end

    // Tap follows len at once, over the existing history
    assign dout = stage[len];

    // Length register must always address a real stage
    property p_len_in_range;
        @(posedge clk) disable iff (er)
        len < DEPTH;
    endproperty

    a_len_in_range : assert property (p_len_in_range)
        else $error("delay_line: len %0d out of range", len);

    // No shift at this edge and the tap unchanged, so the output holds
    property p_hold_when_idle;
        @(posedge clk) disable iff (er)
        !shift_en ##1 ($stable(len) && $stable(shift_en)) |-> $stable(dout);
    endproperty

    a_hold_when_idle : assert property (p_hold_when_idle)
        else $error("delay_line: dout moved with shift disabled");

endmodule

`default_nettype wire

// File: delay_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module delay_cfg_regs
    import delay_pkg::*;
#(
    parameter int  DEPTH = 16,
    localparam int LEN_W = $clog2(DEPTH)
) (
    input  wire logic              clk,
    input  wire logic              er,
    input  wire cfg_wr_t           cfg,
    output logic [LEN_W-1:0]       len0,
    output logic [LEN_W-1:0]       len1,
    output logic                   src_lfsr,
    output logic [LFSR_W-1:0]      seed,
    output logic                   seed_load
);

    localparam logic [LEN_W-1:0] LEN_RESET = LEN_W'(DEPTH - 1);

    logic seed_wr;  // Accepted seed write this cycle

    // Zero would lock the LFSR up, so it is dropped
    assign seed_wr = cfg.wr && (cfg.addr == CFG_SEED) && (cfg.wdata != '0);

    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            len0      <= LEN_RESET;
            len1      <= LEN_RESET;
            src_lfsr  <= 1'b0;
            seed      <= SEED_RESET;
            seed_load <= 1'b0;
        end else begin
            seed_load <= seed_wr;  // Pulse in the cycle after the write
            if (cfg.wr) begin
                case (cfg.addr)
                    CFG_LEN0: len0     <= cfg.wdata[LEN_W-1:0];
                    CFG_LEN1: len1     <= cfg.wdata[LEN_W-1:0];
                    CFG_CTRL: src_lfsr <= cfg.wdata[0];
                    CFG_SEED: begin
                        if (seed_wr) begin
                            seed <= cfg.wdata[LFSR_W-1:0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Load pulse is a single cycle wide
    property p_seed_load_pulse;
        @(posedge clk) disable iff (er)
        seed_load |=> !seed_load;
    endproperty

    a_seed_load_pulse : assert property (p_seed_load_pulse)
        else $error("delay_cfg_regs: seed_load held for two cycles");

endmodule

`default_nettype wire

// File: lfsr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_gen
    import delay_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              er,
    input  wire logic [LFSR_W-1:0] seed,
    input  wire logic              seed_load,
    input  wire logic              step,
    output logic [LFSR_W-1:0]      word
);

    logic [LFSR_W-1:0] state;
    logic              fb;

    // Taps 16, 15, 13, 4
    assign fb = state[15] ^ state[14] ^ state[12] ^ state[3];

    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            state <= SEED_RESET;
        end else if (seed_load) begin  // Load wins over step
            state <= seed;
        end else if (step) begin
            state <= {state[LFSR_W-2:0], fb};
        end
    end

    assign word = state;

    // All-zero is the lock-up state
    property p_state_nonzero;
        @(posedge clk) disable iff (er)
        state != '0;
    endproperty

    a_state_nonzero : assert property (p_state_nonzero)
        else $error("lfsr_gen: state reached zero");

endmodule

`default_nettype wire

// File: delay_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module delay_bank_top
    import delay_pkg::*;
#(
    parameter int  DEPTH = 16,
    localparam int LEN_W = $clog2(DEPTH)
) (
    input  wire logic       clk,
    input  wire logic       er,
    input  wire cfg_wr_t    cfg,
    input  wire logic [1:0] shift_en,   // One enable per lane
    input  wire sample_t    in_sample,
    input  wire flags_t     in_flags,
    output sample_t         out_sample,
    output flags_t          out_flags
);

    logic [LEN_W-1:0]  len0;
    logic [LEN_W-1:0]  len1;
    logic              src_lfsr;
    logic [LFSR_W-1:0] seed;
    logic              seed_load;
    logic [LFSR_W-1:0] lfsr_word;
    logic              lfsr_step;
    sample_t           lane0_din;

    delay_cfg_regs #(
        .DEPTH (DEPTH)
    ) i_delay_cfg_regs (
        .clk       (clk),
        .er        (er),
        .cfg       (cfg),
        .len0      (len0),
        .len1      (len1),
        .src_lfsr  (src_lfsr),
        .seed      (seed),
        .seed_load (seed_load)
    );

    // LFSR only advances while lane 0 consumes it
    assign lfsr_step = shift_en[0] & src_lfsr;

    lfsr_gen i_lfsr_gen (
        .clk       (clk),
        .er        (er),
        .seed      (seed),
        .seed_load (seed_load),
        .step      (lfsr_step),
        .word      (lfsr_word)
    );

    // Bits 15..4 to data, 3..0 to tag
    assign lane0_din = src_lfsr ? sample_t'(lfsr_word) : in_sample;

    delay_line #(
        .payload_t (sample_t),
        .DEPTH     (DEPTH)
    ) i_lane0 (
        .clk      (clk),
        .er       (er),
        .shift_en (shift_en[0]),
        .len      (len0),
        .din      (lane0_din),
        .dout     (out_sample)
    );

    delay_line #(
        .payload_t (flags_t),
        .DEPTH     (DEPTH)
    ) i_lane1 (
        .clk      (clk),
        .er       (er),
        .shift_en (shift_en[1]),
        .len      (len1),
        .din      (in_flags),
        .dout     (out_flags)
    );

endmodule

`default_nettype wire

// File: tb_delay_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_delay_checker
    import delay_pkg::*;
#(
    parameter int  DEPTH = 16,
    localparam int LEN_W = $clog2(DEPTH)
) (
    input  wire logic       clk,
    input  wire logic       er,
    input  wire cfg_wr_t    cfg,
    input  wire logic [1:0] shift_en,
    input  wire sample_t    in_sample,
    input  wire flags_t     in_flags,
    input  wire sample_t    out_sample,
    input  wire flags_t     out_flags,
    output int              error_count
);

    sample_t           hist0 [DEPTH];  // hist0[0] is the newest
    flags_t            hist1 [DEPTH];
    logic [LEN_W-1:0]  m_len0;
    logic [LEN_W-1:0]  m_len1;
    logic              m_src_lfsr;
    logic [LFSR_W-1:0] m_seed;
    logic              m_seed_load;
    logic [LFSR_W-1:0] m_lfsr;
    sample_t           exp_s;
    flags_t            exp_f;
    int                errors = 0;

    assign error_count = errors;

    // Fibonacci step with feedback from bits 15, 14, 12 and 3
    function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] s);
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    always @(posedge clk or posedge er) begin
        if (er) begin
            for (int k = 0; k < DEPTH; k++) begin
                hist0[k] = '0;
                hist1[k] = '0;
            end
            m_len0      = LEN_W'(DEPTH - 1);
            m_len1      = LEN_W'(DEPTH - 1);
            m_src_lfsr  = 1'b0;
            m_seed      = SEED_RESET;
            m_seed_load = 1'b0;
            m_lfsr      = SEED_RESET;
        end else begin
            // Lanes use the pre-edge LFSR word and source select
            if (shift_en[0]) begin
                for (int k = DEPTH - 1; k > 0; k--) begin
                    hist0[k] = hist0[k-1];
                end
                hist0[0] = m_src_lfsr ? m_lfsr : in_sample;
            end
            if (shift_en[1]) begin
                for (int k = DEPTH - 1; k > 0; k--) begin
                    hist1[k] = hist1[k-1];
                end
                hist1[0] = in_flags;
            end
            if (m_seed_load) begin
                m_lfsr = m_seed;  // Load beats step
            end else if (shift_en[0] && m_src_lfsr) begin
                m_lfsr = lfsr_next(m_lfsr);
            end
            m_seed_load = cfg.wr && (cfg.addr == CFG_SEED) && (cfg.wdata != 16'h0000);
            if (cfg.wr) begin
                case (cfg.addr)
                    CFG_LEN0: m_len0 = cfg.wdata[LEN_W-1:0];
                    CFG_LEN1: m_len1 = cfg.wdata[LEN_W-1:0];
                    CFG_CTRL: m_src_lfsr = cfg.wdata[0];
                    default: begin
                        if (cfg.wdata != 16'h0000) m_seed = cfg.wdata;
                    end
                endcase
            end
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        exp_s = hist0[m_len0];
        exp_f = hist1[m_len1];
        if (out_sample !== exp_s) begin
            errors++;
            $display("** Error at %0t ns: lane 0 expected %h, got %h", $time, exp_s, out_sample);
        end
        if (out_flags !== exp_f) begin
            errors++;
            $display("** Error at %0t ns: lane 1 expected %h, got %h", $time, exp_f, out_flags);
        end
    end

endmodule

`default_nettype wire

// File: tb_delay_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_delay_bank
    import delay_pkg::*;
#(
    parameter int DEPTH = 16
);

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int RANDOM_CYCLES  = 300;
    localparam int LIVE_CYCLES    = 200;
    localparam int LFSR_CYCLES    = 200;
    localparam int ARESET_CYCLES  = 120;
    localparam int TEST_CYCLES    = RESET_CYCLES + DEPTH + 4 + RANDOM_CYCLES + 4
                                  + LIVE_CYCLES + LFSR_CYCLES + 8 + ARESET_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    localparam logic [31:0] RAND_SEED = 32'h6c3a;

    logic       clk;
    logic       er;
    cfg_wr_t    cfg;
    logic [1:0] shift_en;
    sample_t    in_sample;
    flags_t     in_flags;
    sample_t    out_sample;
    flags_t     out_flags;
    int         chk_errors;
    int         tb_errors    = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         cycle_count  = 0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    delay_bank_top #(
        .DEPTH (DEPTH)
    ) i_delay_bank_top (
        .clk        (clk),
        .er         (er),
        .cfg        (cfg),
        .shift_en   (shift_en),
        .in_sample  (in_sample),
        .in_flags   (in_flags),
        .out_sample (out_sample),
        .out_flags  (out_flags)
    );

    tb_delay_checker #(
        .DEPTH (DEPTH)
    ) i_delay_checker (
        .clk         (clk),
        .er          (er),
        .cfg         (cfg),
        .shift_en    (shift_en),
        .in_sample   (in_sample),
        .in_flags    (in_flags),
        .out_sample  (out_sample),
        .out_flags   (out_flags),
        .error_count (chk_errors)
    );

    // One clock of stimulus, optionally with a register write
    task automatic drive_cycle(input logic do_wr, input logic [1:0] waddr,
                               input logic [15:0] wval, input logic rand_en);
        logic [15:0] r16;
        logic [7:0]  r8;
        logic [1:0]  r2;
        r16 = 16'($urandom);
        r8  = 8'($urandom);
        r2  = rand_en ? 2'($urandom) : 2'b11;
        @(posedge clk);
        cfg       <= '{wr: do_wr, addr: waddr, wdata: wval};
        in_sample <= r16;
        in_flags  <= r8;
        shift_en  <= r2;
    endtask

    task automatic run_random(input int cycles);
        repeat (cycles) drive_cycle(1'b0, 2'd0, 16'h0000, 1'b1);
    endtask

    task automatic write_reg(input logic [1:0] waddr, input logic [15:0] wval);
        drive_cycle(1'b1, waddr, wval, 1'b1);
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        int errs;
        errs = chk_errors + tb_errors - errs_at_start;
        if (errs == 0) begin
            tests_passed++;
            $display("[%0t ns] Test %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t ns] Test %s: %0d mismatches", $time, name, errs);
        end
    endtask

    initial begin
        int          seed_draw;
        int          start;
        logic [15:0] first_s;
        logic [7:0]  first_f;
        logic [15:0] exp_s;
        logic [7:0]  exp_f;
        logic [15:0] seed_val;
        seed_draw = $urandom(RAND_SEED);
        er        = 1'b1;
        cfg       = '0;
        shift_en  = 2'b00;
        in_sample = '0;
        in_flags  = '0;

        // Reset state and default length
        repeat (RESET_CYCLES) @(posedge clk);
        er <= 1'b0;
        start   = chk_errors + tb_errors;
        first_s = 16'($urandom) | 16'h0001;
        first_f = 8'($urandom) | 8'h01;
        @(posedge clk);
        in_sample <= first_s;
        in_flags  <= first_f;
        shift_en  <= 2'b11;
        for (int n = 1; n <= DEPTH + 1; n++) begin
            @(posedge clk);
            in_sample <= '0;
            in_flags  <= '0;
            @(negedge clk);
            exp_s = (n == DEPTH) ? first_s : 16'h0000;
            exp_f = (n == DEPTH) ? first_f : 8'h00;
            if (out_sample !== exp_s || out_flags !== exp_f) begin
                tb_errors++;
                $display("** Error at %0t ns: after %0d edges expected %h/%h, got %h/%h",
                         $time, n, exp_s, exp_f, out_sample, out_flags);
            end
        end
        finish_test("reset state", start);

        start = chk_errors + tb_errors;
        write_reg(CFG_LEN0, 16'($urandom % DEPTH));
        write_reg(CFG_LEN1, 16'($urandom % DEPTH));
        run_random(RANDOM_CYCLES);
        finish_test("random delay", start);

        // Rewrite lengths mid-stream
        start = chk_errors + tb_errors;
        for (int i = 0; i < LIVE_CYCLES / 25; i++) begin
            write_reg((i % 2 == 0) ? CFG_LEN0 : CFG_LEN1, 16'($urandom % DEPTH));
            run_random(24);
        end
        finish_test("live length change", start);

        start = chk_errors + tb_errors;
        write_reg(CFG_CTRL, 16'h0001);
        seed_val = 16'($urandom);
        if (seed_val == 16'h0000) seed_val = 16'h0001;
        write_reg(CFG_SEED, seed_val);
        run_random(LFSR_CYCLES - 50);
        write_reg(CFG_SEED, 16'h0000);  // Must be ignored
        run_random(48);
        finish_test("lfsr source", start);

        // Reset pulse placed between clock edges
        start = chk_errors + tb_errors;
        run_random(40);
        @(posedge clk);
        #(CLK_PERIOD / 4);
        er <= 1'b1;
        @(negedge clk);
        if (out_sample !== 16'h0000 || out_flags !== 8'h00) begin
            tb_errors++;
            $display("** Error at %0t ns: outputs %h/%h not cleared by reset",
                     $time, out_sample, out_flags);
        end
        #(CLK_PERIOD / 4);
        er <= 1'b0;
        run_random(30);
        write_reg(CFG_CTRL, 16'h0001);  // LFSR restarts from reset seed
        run_random(ARESET_CYCLES - 73);
        finish_test("async reset", start);

        repeat (2) @(posedge clk);
        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, chk_errors + tb_errors);
        if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
delay_pkg.sv
delay_line.sv
delay_cfg_regs.sv
lfsr_gen.sv
delay_bank_top.sv
tb_delay_checker.sv
tb_delay_bank.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_delay_bank
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
